//--- hdl/fetch_consts.svh
/*
 * Width, depth and reset constants of the RV64 fetch stage.
 */

`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Data path and PC width.
`define XLEN     64
// Raw immediate field, instruction bits 31 to 7.
`define IMM_W    25
// Instruction word width.
`define ILEN     32
// Word index width of the instruction memory, 256 words.
`define MEM_AW   8
// First fetch address after reset.
`define RESET_PC 64'h0

`endif

//--- hdl/rv_isa_pkg.sv
/*
 * ISA types: instruction and data vectors, the raw immediate field,
 * the opcode enum and the immediate-type encoding.
 */

`include "fetch_consts.svh"

package rv_isa_pkg;

    // Vectors with a meaning of their own.
    typedef logic [`ILEN-1:0]  instr_t;
    typedef logic [`XLEN-1:0]  xlen_t;
    typedef logic [`IMM_W-1:0] imm_field_t;

    // Major opcodes handled by the fetch stage.
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // Immediate layouts, as selected in the extender.
    typedef enum logic [2:0] {
        IMM_I   = 3'd0,
        IMM_S   = 3'd1,
        IMM_B   = 3'd2,
        IMM_J   = 3'd3,
        IMM_U   = 3'd4,
        IMM_CSR = 3'd5
    } imm_type_e;

endpackage

//--- hdl/fetch_pkg.sv
/*
 * Fetch-side types: memory word index, fetch FSM states and the
 * owner of the shared memory port.
 */

`include "fetch_consts.svh"

package fetch_pkg;

    // Word index into the instruction memory.
    typedef logic [`MEM_AW-1:0] mem_idx_t;

    // Fetch FSM.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        RESP = 2'd2
    } fetch_state_e;

    // Who drives the memory port in a given cycle.
    typedef enum logic [1:0] {
        OWN_NONE  = 2'd0,
        OWN_HOST  = 2'd1,
        OWN_FETCH = 2'd2
    } owner_e;

endpackage

//--- hdl/extend_imm.sv
/*
 * Immediate extender: builds the I, S, B, J, U and CSR immediates
 * from instruction bits 31 to 7.
 */

`timescale 1ns/1ps

`include "fetch_consts.svh"

module extend_imm (
    // Layout select.
    input  rv_isa_pkg::imm_type_e  i_imm_type,
    // Instruction bits 31 to 7.
    input  rv_isa_pkg::imm_field_t i_imm,
    // Extended immediate.
    output rv_isa_pkg::xlen_t      o_imm_ext
);

    import rv_isa_pkg::*;

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_j;
    xlen_t imm_u;
    xlen_t imm_csr;

    // ----------------------------------------------------------------------
    // Layouts. Field bit n is instruction bit n+7.
    // ----------------------------------------------------------------------

    // I: imm[11:0] = instr[31:20].
    assign imm_i = {{(`XLEN-12){i_imm[24]}}, i_imm[24:13]};
    // S: instr[31:25] and instr[11:7].
    assign imm_s = {{(`XLEN-12){i_imm[24]}}, i_imm[24:18], i_imm[4:0]};
    // B: bit 11 sits in instr[7], bit 0 is always zero.
    assign imm_b = {{(`XLEN-12){i_imm[24]}}, i_imm[0], i_imm[23:18], i_imm[4:1], 1'b0};
    // J: 21-bit offset, scrambled as in the ISA.
    assign imm_j = {{(`XLEN-20){i_imm[24]}}, i_imm[12:5], i_imm[13], i_imm[23:14], 1'b0};
    // U: upper 20 bits, sign carried above bit 31.
    assign imm_u = {{(`XLEN-32){i_imm[24]}}, i_imm[24:5], 12'b0};
    // CSR zimm from the rs1 slot, zero extended.
    assign imm_csr = {{(`XLEN-5){1'b0}}, i_imm[12:8]};

    // ----------------------------------------------------------------------
    // Layout select. Unknown codes fall back to I.
    // ----------------------------------------------------------------------
    always_comb begin
        case (i_imm_type)
            IMM_I:   o_imm_ext = imm_i;
            IMM_S:   o_imm_ext = imm_s;
            IMM_B:   o_imm_ext = imm_b;
            IMM_J:   o_imm_ext = imm_j;
            IMM_U:   o_imm_ext = imm_u;
            IMM_CSR: o_imm_ext = imm_csr;
            default: o_imm_ext = imm_i;
        endcase
    end

endmodule

//--- hdl/imm_decoder.sv
/*
 * Immediate decoder: opcode to immediate type, branch and jump flags,
 * and the extended immediate through extend_imm.
 */

`timescale 1ns/1ps

module imm_decoder (
    // Instruction under decode.
    input  rv_isa_pkg::instr_t i_instr,
    // Extended immediate.
    output rv_isa_pkg::xlen_t  o_imm,
    // Conditional branch opcode.
    output logic               o_is_branch,
    // JAL opcode.
    output logic               o_is_jal
);

    import rv_isa_pkg::*;

    opcode_e    opcode;
    imm_type_e  imm_type;
    imm_field_t imm_field;

    // Opcode and raw immediate field.
    assign opcode    = opcode_e'(i_instr[6:0]);
    assign imm_field = i_instr[31:7];

    // ----------------------------------------------------------------------
    // Opcode to immediate layout.
    // ----------------------------------------------------------------------
    always_comb begin
        case (opcode)
            LOAD,
            OP_IMM,
            JALR:    imm_type = IMM_I;
            STORE:   imm_type = IMM_S;
            BRANCH:  imm_type = IMM_B;
            JAL:     imm_type = IMM_J;
            LUI,
            AUIPC:   imm_type = IMM_U;
            SYSTEM:  imm_type = IMM_CSR;
            // Unknown opcodes read as I.
            default: imm_type = IMM_I;
        endcase
    end

    // Control-flow flags for the predictor.
    assign o_is_branch = (opcode == BRANCH);
    assign o_is_jal    = (opcode == JAL);

    // ----------------------------------------------------------------------
    // Extender.
    // ----------------------------------------------------------------------
    extend_imm u_extend_imm (
        .i_imm_type (imm_type),
        .i_imm      (imm_field),
        .o_imm_ext  (o_imm)
    );

endmodule

//--- hdl/mem_arbiter.sv
/*
 * Fixed-priority arbiter for the instruction memory port.
 * Host writes always win, fetch reads take the free cycles.
 */

`timescale 1ns/1ps

module mem_arbiter (
    // Host side.
    input  logic                 i_host_we,
    input  fetch_pkg::mem_idx_t  i_host_addr,
    input  rv_isa_pkg::instr_t   i_host_wdata,
    // Fetch side.
    input  logic                 i_fetch_req,
    input  fetch_pkg::mem_idx_t  i_fetch_idx,
    output logic                 o_fetch_gnt,
    // Memory side.
    output logic                 o_mem_en,
    output logic                 o_mem_we,
    output fetch_pkg::mem_idx_t  o_mem_idx,
    output rv_isa_pkg::instr_t   o_mem_wdata,
    // Port owner of this cycle.
    output fetch_pkg::owner_e    o_owner
);

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    // Grant is combinational, fetch only in cycles free of host writes.
    assign o_fetch_gnt = i_fetch_req & ~i_host_we;

    // ----------------------------------------------------------------------
    // Port mux.
    // ----------------------------------------------------------------------
    always_comb begin
        o_mem_en    = 1'b0;
        o_mem_we    = 1'b0;
        o_mem_idx   = i_fetch_idx;
        o_mem_wdata = instr_t'('0);
        o_owner     = OWN_NONE;
        if (i_host_we) begin
            // Host write.
            o_mem_en    = 1'b1;
            o_mem_we    = 1'b1;
            o_mem_idx   = i_host_addr;
            o_mem_wdata = i_host_wdata;
            o_owner     = OWN_HOST;
        end else if (i_fetch_req) begin
            // Fetch read, write data unused.
            o_mem_en = 1'b1;
            o_owner  = OWN_FETCH;
        end
    end

endmodule

//--- hdl/instr_mem.sv
/*
 * Single-port instruction memory, one word per index.
 * Synchronous write, registered read data.
 */

`timescale 1ns/1ps

`include "fetch_consts.svh"

module instr_mem (
    input  logic                 clk,
    // Port enable and write enable.
    input  logic                 i_en,
    input  logic                 i_we,
    // Word index and write data.
    input  fetch_pkg::mem_idx_t  i_idx,
    input  rv_isa_pkg::instr_t   i_wdata,
    // Read data, one cycle after a read.
    output rv_isa_pkg::instr_t   o_rdata
);

    import rv_isa_pkg::*;

    // Word array, contents come from host writes only.
    instr_t mem [0:(1 << `MEM_AW)-1];

    // ----------------------------------------------------------------------
    // Write port.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_en && i_we) begin
            mem[i_idx] <= i_wdata;
        end
    end

    // ----------------------------------------------------------------------
    // Read port.
    // ----------------------------------------------------------------------
    // Read data holds its value through writes and idle cycles.
    always_ff @(posedge clk) begin
        if (i_en && !i_we) begin
            o_rdata <= mem[i_idx];
        end
    end

endmodule

//--- hdl/fetch_unit.sv
/*
 * Fetch unit: PC register, IDLE/REQ/RESP FSM, static next-PC
 * prediction and the registered result with its valid pulse.
 */

`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 i_rst_n,
    // Fetch enable level.
    input  logic                 i_run,
    // Memory request, held until granted.
    output logic                 o_req,
    output fetch_pkg::mem_idx_t  o_req_idx,
    input  logic                 i_gnt,
    input  rv_isa_pkg::instr_t   i_rdata,
    // Decoder loop.
    output rv_isa_pkg::instr_t   o_dec_instr,
    input  rv_isa_pkg::xlen_t    i_dec_imm,
    input  logic                 i_dec_is_branch,
    input  logic                 i_dec_is_jal,
    // Result, valid for one cycle.
    output logic                 o_valid,
    output rv_isa_pkg::xlen_t    o_pc,
    output rv_isa_pkg::instr_t   o_instr,
    output rv_isa_pkg::xlen_t    o_imm,
    output rv_isa_pkg::xlen_t    o_next_pc
);

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    fetch_state_e state;
    fetch_state_e state_nxt;
    xlen_t        pc;
    xlen_t        pred_pc;
    logic         taken;

    // ----------------------------------------------------------------------
    // FSM.
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (i_run) state_nxt = REQ;
            // Wait here while the host owns the memory.
            REQ:  if (i_gnt) state_nxt = RESP;
            // Read done, continue or stop.
            RESP: state_nxt = i_run ? REQ : IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Request level and word index, fetch wraps over the 1 KiB memory.
    assign o_req     = (state == REQ);
    assign o_req_idx = pc[`MEM_AW+1:2];

    // Read data is live in RESP.
    assign o_dec_instr = i_rdata;

    // ----------------------------------------------------------------------
    // Static prediction.
    // ----------------------------------------------------------------------
    // JAL always, branches only backward.
    assign taken   = i_dec_is_jal | (i_dec_is_branch & i_dec_imm[`XLEN-1]);
    assign pred_pc = taken ? (pc + i_dec_imm) : (pc + xlen_t'(4));

    // PC and valid pulse.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc      <= `RESET_PC;
            o_valid <= 1'b0;
        end else begin
            o_valid <= (state == RESP);
            if (state == RESP) begin
                pc <= pred_pc;
            end
        end
    end

    // Result payload, loaded with the valid pulse.
    always_ff @(posedge clk) begin
        if (state == RESP) begin
            o_pc      <= pc;
            o_instr   <= i_rdata;
            o_imm     <= i_dec_imm;
            o_next_pc <= pred_pc;
        end
    end

endmodule

//--- hdl/fetch_stage_top.sv
/*
 * Fetch stage top level with the arbiter, the instruction memory,
 * the fetch unit and the immediate decoder.
 */

`timescale 1ns/1ps

module fetch_stage_top (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_run,
    // Host program port.
    input  logic                 i_host_we,
    input  fetch_pkg::mem_idx_t  i_host_addr,
    input  rv_isa_pkg::instr_t   i_host_wdata,
    // Fetch result.
    output logic                 o_valid,
    output rv_isa_pkg::xlen_t    o_pc,
    output rv_isa_pkg::instr_t   o_instr,
    output rv_isa_pkg::xlen_t    o_imm,
    output rv_isa_pkg::xlen_t    o_next_pc
);

    // Fetch request path.
    logic                 fetch_req;
    fetch_pkg::mem_idx_t  fetch_idx;
    logic                 fetch_gnt;
    // Memory port.
    logic                 mem_en;
    logic                 mem_we;
    fetch_pkg::mem_idx_t  mem_idx;
    rv_isa_pkg::instr_t   mem_wdata;
    rv_isa_pkg::instr_t   mem_rdata;
    // Owner of the memory port in each cycle.
    fetch_pkg::owner_e    mem_owner;
    // Decoder loop.
    rv_isa_pkg::instr_t   dec_instr;
    rv_isa_pkg::xlen_t    dec_imm;
    logic                 dec_is_branch;
    logic                 dec_is_jal;

    // ----------------------------------------------------------------------
    // Memory side.
    // ----------------------------------------------------------------------
    mem_arbiter u_mem_arbiter (
        .i_host_we    (i_host_we),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .i_fetch_req  (fetch_req),
        .i_fetch_idx  (fetch_idx),
        .o_fetch_gnt  (fetch_gnt),
        .o_mem_en     (mem_en),
        .o_mem_we     (mem_we),
        .o_mem_idx    (mem_idx),
        .o_mem_wdata  (mem_wdata),
        .o_owner      (mem_owner)
    );

    instr_mem u_instr_mem (
        .clk     (clk),
        .i_en    (mem_en),
        .i_we    (mem_we),
        .i_idx   (mem_idx),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

    // ----------------------------------------------------------------------
    // Fetch and decode.
    // ----------------------------------------------------------------------
    fetch_unit u_fetch_unit (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_run           (i_run),
        .o_req           (fetch_req),
        .o_req_idx       (fetch_idx),
        .i_gnt           (fetch_gnt),
        .i_rdata         (mem_rdata),
        .o_dec_instr     (dec_instr),
        .i_dec_imm       (dec_imm),
        .i_dec_is_branch (dec_is_branch),
        .i_dec_is_jal    (dec_is_jal),
        .o_valid         (o_valid),
        .o_pc            (o_pc),
        .o_instr         (o_instr),
        .o_imm           (o_imm),
        .o_next_pc       (o_next_pc)
    );

    imm_decoder u_imm_decoder (
        .i_instr     (dec_instr),
        .o_imm       (dec_imm),
        .o_is_branch (dec_is_branch),
        .o_is_jal    (dec_is_jal)
    );

endmodule

//--- tb/fetch_stage_asserts.sv
/*
 * Concurrent checks on memory arbitration, the fetch request level
 * and the valid pulse, bound into the fetch stage top level.
 */

`timescale 1ns/1ps

module fetch_stage_asserts (
    input logic              clk,
    input logic              i_rst_n,
    input logic              i_host_we,
    input logic              i_fetch_req,
    input logic              i_fetch_gnt,
    input fetch_pkg::owner_e i_owner,
    input logic              i_valid
);

    import fetch_pkg::*;

    // A granted fetch must own the memory port.
    // The port goes to the fetch side only in cycles without a host write.
    a_no_gnt_on_write: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_fetch_gnt |-> (i_owner == OWN_FETCH)
    ) else $error("fetch unit granted during a host write");

    // Valid is a single-cycle pulse.
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_valid |=> !i_valid
    ) else $error("valid high on two consecutive cycles");

    // Request level holds until granted.
    a_req_hold: assert property (
        @(posedge clk) disable iff (!i_rst_n) (i_fetch_req && !i_fetch_gnt) |=> i_fetch_req
    ) else $error("fetch request dropped before its grant");

endmodule

bind fetch_stage_top fetch_stage_asserts u_fetch_stage_asserts (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_host_we   (i_host_we),
    .i_fetch_req (fetch_req),
    .i_fetch_gnt (fetch_gnt),
    .i_owner     (mem_owner),
    .i_valid     (o_valid)
);

//--- tb/fetch_stage_tb.sv
/*
 * Fetch stage testbench with program load, reference model, result
 * comparison, host contention stimulus, reports and watchdog.
 */

`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_stage_tb;

    import rv_isa_pkg::*;

    // Results checked without and with host writes.
    localparam int QUIET_RESULTS = 80;
    localparam int BUSY_RESULTS  = 80;
    localparam int WORDS         = 1 << `MEM_AW;
    localparam int RESET_CYCLES  = 10;
    // One edge to leave IDLE, then REQ and RESP.
    localparam int FIRST_LATENCY = 3;
    // Reset, program load, then 20 cycles per expected result.
    localparam int LIMIT_CYCLES  = RESET_CYCLES + WORDS + 20 * (QUIET_RESULTS + BUSY_RESULTS);

    logic                clk = 1'b0;
    logic                rst_n;
    logic                run;
    logic                host_we;
    fetch_pkg::mem_idx_t host_addr;
    instr_t              host_wdata;
    logic                o_valid;
    xlen_t               o_pc;
    instr_t              o_instr;
    xlen_t               o_imm;
    xlen_t               o_next_pc;

    // Memory mirror and reference state.
    instr_t mirror [0:WORDS-1];
    integer seed;
    string  test_name;
    int     test_errors;
    int     total_errors;
    int     tests_done;
    int     results;
    int     cycle;
    int     last_valid_cycle;
    int     wait_cycles;
    int     offset;
    logic   busy;
    xlen_t  exp_pc;
    xlen_t  prev_next;
    instr_t exp_instr;
    xlen_t  exp_imm;
    xlen_t  exp_next;
    // Word index of the fetch in progress, seen at the rising edge.
    fetch_pkg::mem_idx_t patch_base;

    fetch_stage_top dut_i (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_run        (run),
        .i_host_we    (host_we),
        .i_host_addr  (host_addr),
        .i_host_wdata (host_wdata),
        .o_valid      (o_valid),
        .o_pc         (o_pc),
        .o_instr      (o_instr),
        .o_imm        (o_imm),
        .o_next_pc    (o_next_pc)
    );

    // 4 ns clock.
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // -------------------------------------------------------------------
    // Program generation and reference model.
    // -------------------------------------------------------------------
    function automatic logic [6:0] pick_opcode(input int sel);
        case (sel)
            0:       return LOAD;
            1:       return OP_IMM;
            2:       return AUIPC;
            3:       return STORE;
            4:       return LUI;
            5:       return BRANCH;
            6:       return JALR;
            7:       return JAL;
            8:       return SYSTEM;
            // The custom-0 slot is unknown to the decoder.
            default: return 7'b0001011;
        endcase
    endfunction

    // Random fields above a chosen opcode.
    function automatic instr_t rand_instr();
        logic [31:0] r;
        int          sel;
        r   = $random(seed);
        sel = int'($unsigned($random(seed)) % 10);
        return {r[31:7], pick_opcode(sel)};
    endfunction

    // Expected word, immediate and predicted next PC at a given PC.
    function automatic void ref_fetch(input xlen_t pc, output instr_t ins,
                                      output xlen_t imm, output xlen_t nxt);
        logic taken;
        ins   = mirror[pc[`MEM_AW+1:2]];
        taken = 1'b0;
        case (ins[6:0])
            STORE:  imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
            BRANCH: begin
                imm   = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                // Backward branches only.
                taken = ins[31];
            end
            JAL: begin
                imm   = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                taken = 1'b1;
            end
            LUI, AUIPC: imm = {{32{ins[31]}}, ins[31:12], 12'b0};
            SYSTEM:     imm = {59'b0, ins[19:15]};
            // LOAD, OP_IMM, JALR and unknown opcodes.
            default:    imm = {{52{ins[31]}}, ins[31:20]};
        endcase
        nxt = taken ? (pc + imm) : (pc + 64'd4);
    endfunction

    task automatic check_value(input string what, input xlen_t expected, input xlen_t actual);
        assert (expected === actual) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic end_test();
        $display("test %s finished with %0d error(s)", test_name, test_errors);
        total_errors += test_errors;
        test_errors = 0;
        tests_done++;
    endtask

    // -------------------------------------------------------------------
    // Comparison of every result against the reference.
    // -------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && o_valid) begin
            ref_fetch(exp_pc, exp_instr, exp_imm, exp_next);
            check_value("pc", exp_pc, o_pc);
            check_value("instr", xlen_t'(exp_instr), xlen_t'(o_instr));
            check_value("imm", exp_imm, o_imm);
            check_value("next_pc", exp_next, o_next_pc);
            if (results > 0) begin
                check_value("pc chain", prev_next, o_pc);
                // Full rate without host writes.
                if (!busy) begin
                    check_value("valid gap", xlen_t'(2), xlen_t'(cycle - last_valid_cycle));
                end
            end
            last_valid_cycle = cycle;
            prev_next        = o_next_pc;
            exp_pc           = exp_next;
            results++;
        end
    end

    // Ends a run that stops producing results.
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles, fetch stopped", LIMIT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // -------------------------------------------------------------------
    // Test sequence.
    // -------------------------------------------------------------------
    initial begin
        seed         = 32'hbe729188;
        rst_n        = 1'b0;
        run          = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        busy         = 1'b0;
        cycle        = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_done   = 0;
        results      = 0;
        exp_pc       = `RESET_PC;
        test_name    = "reset_state";
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("valid in reset", xlen_t'(0), xlen_t'(o_valid));
        end
        rst_n = 1'b1;
        // Whole memory loaded, so every target lands on a program word.
        for (int i = 0; i < WORDS; i++) begin
            host_we    = 1'b1;
            host_addr  = fetch_pkg::mem_idx_t'(i);
            host_wdata = rand_instr();
            mirror[i]  = host_wdata;
            @(negedge clk);
            check_value("valid while idle", xlen_t'(0), xlen_t'(o_valid));
        end
        host_we = 1'b0;
        run     = 1'b1;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!o_valid && wait_cycles < 10);
        check_value("first latency", xlen_t'(FIRST_LATENCY), xlen_t'(wait_cycles));
        check_value("first pc", `RESET_PC, o_pc);
        end_test();

        test_name = "quiet_run";
        while (results < QUIET_RESULTS) @(negedge clk);
        end_test();

        // Patch words just ahead of the word in flight.
        test_name = "host_contention";
        busy      = 1'b1;
        while (results < QUIET_RESULTS + BUSY_RESULTS) begin
            @(posedge clk);
            patch_base = exp_pc[`MEM_AW+1:2];
            @(negedge clk);
            host_we = ($unsigned($random(seed)) % 3 == 0);
            if (host_we) begin
                offset             = 1 + int'($unsigned($random(seed)) % 8);
                host_addr          = patch_base + fetch_pkg::mem_idx_t'(offset);
                host_wdata         = rand_instr();
                mirror[host_addr]  = host_wdata;
            end
        end
        @(negedge clk);
        host_we = 1'b0;
        run     = 1'b0;
        repeat (6) @(negedge clk);
        end_test();

        $display("Summary: %0d tests, %0d results checked, %0d errors",
                 tests_done, results, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/fetch_pkg.sv
hdl/extend_imm.sv
hdl/imm_decoder.sv
hdl/mem_arbiter.sv
hdl/instr_mem.sv
hdl/fetch_unit.sv
hdl/fetch_stage_top.sv
tb/fetch_stage_asserts.sv
tb/fetch_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the fetch stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f sim.f --top-module fetch_stage_tb -o fetch_stage_sim

# A failed assertion stops the simulation with a nonzero status.
status=0
./obj_dir/fetch_stage_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"
